//--- hdl/conv_pkg.sv
package conv_pkg;

    // array geometry
    localparam int MAX_MACS   = 64;
    localparam int LANES      = 8;
    localparam int MAX_GROUPS = 8;
    localparam int ELEM_W     = 8;

    // int8 operand element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // one sram read word, lane 0 holds the lowest address
    typedef elem_t [LANES-1:0] lane_word_t;

    // one mac operand vector
    typedef elem_t [MAX_MACS-1:0] mac_vec_t;

    // geometry dimension or stride
    typedef logic [7:0] dim_t;

    // element address into either sram
    typedef logic [15:0] addr_t;

    // lane count, 0 to 64
    typedef logic [6:0] macs_t;

    // group count, 0 to 8
    typedef logic [3:0] group_t;

    // output channel index
    typedef logic [7:0] oc_t;

    // per-group lane counts
    typedef macs_t [MAX_GROUPS-1:0] macs_vec_t;

endpackage

//--- hdl/conv_cfg_if.sv
`timescale 1ns/1ps

interface conv_cfg_if;

    // patch size in elements
    conv_pkg::macs_t  total_macs;
    // elements per kernel row, ker_col * in_channel
    conv_pkg::macs_t  row_len;
    // elements per image row, img_col * in_channel
    conv_pkg::addr_t  img_pitch;
    conv_pkg::dim_t   ker_row;
    // groups per full beat
    conv_pkg::group_t groups;
    conv_pkg::oc_t    out_channel;

    modport ctrl (
        output total_macs, row_len, img_pitch, ker_row, groups, out_channel
    );

    modport fetch (
        input row_len, img_pitch, ker_row
    );

    modport store (
        input total_macs, out_channel
    );

    modport pack (
        input total_macs, groups, out_channel
    );

endinterface

//--- hdl/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            start_i,
    input  conv_pkg::dim_t  img_row_i,
    input  conv_pkg::dim_t  img_col_i,
    input  conv_pkg::dim_t  ker_row_i,
    input  conv_pkg::dim_t  ker_col_i,
    input  conv_pkg::dim_t  in_channel_i,
    input  conv_pkg::dim_t  out_channel_i,
    input  conv_pkg::dim_t  stride_row_i,
    input  conv_pkg::dim_t  stride_col_i,
    conv_cfg_if.ctrl        cfg,
    output logic            load_start_o,
    input  logic            load_done_i,
    output logic            gather_start_o,
    output conv_pkg::addr_t gather_base_o,
    input  logic            gather_done_i,
    output logic            beat_o,
    output conv_pkg::oc_t   beat_oc_o,
    output conv_pkg::dim_t  beat_row_o,
    output conv_pkg::dim_t  beat_col_o,
    output logic            beat_last_o,
    output logic            busy_o
);

    typedef enum logic [2:0] {S_IDLE, S_LOAD, S_GATHER, S_EMIT, S_DONE} state_t;

    state_t state;

    // latched geometry
    conv_pkg::dim_t img_row, img_col, ker_row, ker_col;
    conv_pkg::dim_t in_ch, out_ch, stride_row, stride_col;

    conv_pkg::macs_t  total_macs;
    conv_pkg::addr_t  img_pitch;
    conv_pkg::group_t groups;

    // output position and its image offset
    conv_pkg::dim_t win_row, win_col, row_off, col_off;
    conv_pkg::oc_t  oc_base;

    logic win_end, row_fits, col_fits;

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_i) begin
            img_row    <= img_row_i;
            img_col    <= img_col_i;
            ker_row    <= ker_row_i;
            ker_col    <= ker_col_i;
            in_ch      <= in_channel_i;
            out_ch     <= out_channel_i;
            stride_row <= stride_row_i;
            stride_col <= stride_col_i;
        end
    end

    assign total_macs = 7'(ker_row * ker_col * in_ch);
    assign img_pitch  = img_col * in_ch;

    // groups = min(8, 64 / total_macs) by repeated subtraction
    always_comb begin
        conv_pkg::macs_t rem;
        rem    = 7'(conv_pkg::MAX_MACS);
        groups = '0;
        for (int i = 0; i < conv_pkg::MAX_GROUPS; i++) begin
            if (total_macs != '0 && rem >= total_macs) begin
                rem    = rem - total_macs;
                groups = groups + 1'b1;
            end
        end
    end

    assign cfg.total_macs  = total_macs;
    assign cfg.row_len     = 7'(ker_col * in_ch);
    assign cfg.img_pitch   = img_pitch;
    assign cfg.ker_row     = ker_row;
    assign cfg.groups      = groups;
    assign cfg.out_channel = out_ch;

    // last beat of the window and room for the next position
    assign win_end  = 9'(oc_base) + 9'(groups) >= 9'(out_ch);
    assign row_fits = 10'(row_off) + 10'(stride_row) + 10'(ker_row) <= 10'(img_row);
    assign col_fits = 10'(col_off) + 10'(stride_col) + 10'(ker_col) <= 10'(img_col);

    assign gather_base_o = row_off * img_pitch + col_off * in_ch;

    assign beat_o      = (state == S_EMIT);
    assign beat_oc_o   = oc_base;
    assign beat_row_o  = win_row;
    assign beat_col_o  = win_col;
    assign beat_last_o = win_end && !row_fits && !col_fits;
    assign busy_o      = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state          <= S_IDLE;
            load_start_o   <= 1'b0;
            gather_start_o <= 1'b0;
            oc_base        <= '0;
            win_row        <= '0;
            win_col        <= '0;
            row_off        <= '0;
            col_off        <= '0;
        end else begin
            load_start_o   <= 1'b0;
            gather_start_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state        <= S_LOAD;
                        load_start_o <= 1'b1;
                        win_row      <= '0;
                        win_col      <= '0;
                        row_off      <= '0;
                        col_off      <= '0;
                    end
                end
                S_LOAD: begin
                    if (load_done_i) begin
                        state          <= S_GATHER;
                        gather_start_o <= 1'b1;
                    end
                end
                S_GATHER: begin
                    if (gather_done_i) begin
                        state   <= S_EMIT;
                        oc_base <= '0;
                    end
                end
                S_EMIT: begin
                    if (!win_end) begin
                        oc_base <= oc_base + groups;
                    end else if (row_fits) begin
                        // row is the inner loop
                        win_row        <= win_row + 1'b1;
                        row_off        <= row_off + stride_row;
                        gather_start_o <= 1'b1;
                        state          <= S_GATHER;
                    end else if (col_fits) begin
                        win_row        <= '0;
                        row_off        <= '0;
                        win_col        <= win_col + 1'b1;
                        col_off        <= col_off + stride_col;
                        gather_start_o <= 1'b1;
                        state          <= S_GATHER;
                    end else begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/patch_fetch.sv
`timescale 1ns/1ps

module patch_fetch (
    input  logic                 clk,
    input  logic                 rst,
    conv_cfg_if.fetch            cfg,
    input  logic                 gather_start_i,
    input  conv_pkg::addr_t      gather_base_i,
    output logic                 gather_done_o,
    output logic                 img_rd_o,
    output conv_pkg::addr_t      img_addr_o,
    input  conv_pkg::lane_word_t img_data_i,
    output conv_pkg::mac_vec_t   patch_o
);

    logic            active;
    conv_pkg::dim_t  kr;
    conv_pkg::addr_t row_addr;
    // offset within the kernel row and running patch offset
    conv_pkg::macs_t col, poff;
    conv_pkg::macs_t vld;
    logic            row_end, last_rd;

    // read side aligned with the returning word
    logic            rd_d, last_d;
    conv_pkg::macs_t off_d, vld_d;

    assign vld = (cfg.row_len - col >= 7'(conv_pkg::LANES)) ?
                 7'(conv_pkg::LANES) : cfg.row_len - col;
    assign row_end = (col + 7'(conv_pkg::LANES)) >= cfg.row_len;
    assign last_rd = row_end && (kr + 1'b1 == cfg.ker_row);

    assign img_rd_o   = active;
    assign img_addr_o = row_addr + col;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active        <= 1'b0;
            kr            <= '0;
            col           <= '0;
            poff          <= '0;
            row_addr      <= '0;
            rd_d          <= 1'b0;
            last_d        <= 1'b0;
            gather_done_o <= 1'b0;
        end else begin
            rd_d          <= active;
            last_d        <= active && last_rd;
            gather_done_o <= rd_d && last_d;
            if (gather_start_i) begin
                active   <= 1'b1;
                kr       <= '0;
                col      <= '0;
                poff     <= '0;
                row_addr <= gather_base_i;
            end else if (active) begin
                poff <= poff + vld;
                if (row_end) begin
                    // next kernel row, one image row further
                    col      <= '0;
                    kr       <= kr + 1'b1;
                    row_addr <= row_addr + cfg.img_pitch;
                    if (last_rd) begin
                        active <= 1'b0;
                    end
                end else begin
                    col <= col + 7'(conv_pkg::LANES);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        off_d <= poff;
        vld_d <= vld;
        if (rd_d) begin
            for (int k = 0; k < conv_pkg::LANES; k++) begin
                // partial last word writes only its valid lanes
                if (k < int'(vld_d) && int'(off_d) + k < conv_pkg::MAX_MACS) begin
                    patch_o[int'(off_d) + k] <= img_data_i[k];
                end
            end
        end
    end

endmodule

//--- hdl/weight_store.sv
`timescale 1ns/1ps

module weight_store #(
    parameter int WEIGHT_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst,
    conv_cfg_if.store            cfg,
    input  logic                 load_start_i,
    output logic                 load_done_o,
    output logic                 wgt_rd_o,
    output conv_pkg::addr_t      wgt_addr_o,
    input  conv_pkg::lane_word_t wgt_data_i,
    input  logic                 beat_i,
    input  conv_pkg::oc_t        beat_oc_i,
    output conv_pkg::mac_vec_t   wgt_slice_o
);

    localparam int AW = $clog2(WEIGHT_DEPTH);

    conv_pkg::elem_t wbuf [WEIGHT_DEPTH];

    // weights in the layer and first weight of the beat
    conv_pkg::addr_t total_w, slice_base;
    conv_pkg::addr_t addr_d;
    logic            last_rd, rd_d, last_d;

    assign total_w    = cfg.out_channel * cfg.total_macs;
    assign slice_base = beat_oc_i * cfg.total_macs;
    assign last_rd    = (wgt_addr_o + 16'(conv_pkg::LANES)) >= total_w;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wgt_rd_o    <= 1'b0;
            wgt_addr_o  <= '0;
            rd_d        <= 1'b0;
            last_d      <= 1'b0;
            load_done_o <= 1'b0;
        end else begin
            rd_d        <= wgt_rd_o;
            last_d      <= wgt_rd_o && last_rd;
            load_done_o <= rd_d && last_d;
            if (load_start_i) begin
                wgt_rd_o   <= 1'b1;
                wgt_addr_o <= '0;
            end else if (wgt_rd_o) begin
                if (last_rd) begin
                    wgt_rd_o <= 1'b0;
                end else begin
                    wgt_addr_o <= wgt_addr_o + 16'(conv_pkg::LANES);
                end
            end
        end
    end

    // fill, lanes past the last weight are dropped
    always_ff @(posedge clk) begin
        addr_d <= wgt_addr_o;
        for (int k = 0; k < conv_pkg::LANES; k++) begin
            int idx;
            idx = int'(addr_d) + k;
            if (rd_d && idx < int'(total_w) && idx < WEIGHT_DEPTH) begin
                wbuf[AW'(idx)] <= wgt_data_i[k];
            end
        end
    end

    // 64 weights from the beat's first output channel
    always_ff @(posedge clk) begin
        for (int j = 0; j < conv_pkg::MAX_MACS; j++) begin
            int idx;
            idx = int'(slice_base) + j;
            if (beat_i) begin
                if (idx < int'(total_w) && idx < WEIGHT_DEPTH) begin
                    wgt_slice_o[j] <= wbuf[AW'(idx)];
                end else begin
                    wgt_slice_o[j] <= '0;
                end
            end
        end
    end

endmodule

//--- hdl/mac_packer.sv
`timescale 1ns/1ps

module mac_packer (
    input  logic                clk,
    input  logic                rst,
    conv_cfg_if.pack            cfg,
    input  logic                beat_i,
    input  conv_pkg::oc_t       beat_oc_i,
    input  conv_pkg::dim_t      beat_row_i,
    input  conv_pkg::dim_t      beat_col_i,
    input  logic                beat_last_i,
    input  conv_pkg::mac_vec_t  patch_i,
    input  conv_pkg::mac_vec_t  wgt_slice_i,
    output logic                mac_valid_o,
    output conv_pkg::mac_vec_t  data_mac_o,
    output conv_pkg::mac_vec_t  weight_mac_o,
    output conv_pkg::group_t    num_groups_o,
    output conv_pkg::macs_vec_t num_macs_o,
    output conv_pkg::dim_t      win_row_o,
    output conv_pkg::dim_t      win_col_o,
    output conv_pkg::oc_t       oc_base_o,
    output logic                done_o
);

    conv_pkg::oc_t      oc_left;
    conv_pkg::group_t   active;
    conv_pkg::mac_vec_t data_lanes;
    conv_pkg::macs_t    wgt_limit;

    // last beat of a window may carry fewer groups
    assign oc_left = cfg.out_channel - beat_oc_i;
    assign active  = (8'(cfg.groups) < oc_left) ? cfg.groups : 4'(oc_left);

    // patch repeated once per active group
    always_comb begin
        int j;
        int g;
        j          = 0;
        g          = 0;
        data_lanes = '0;
        for (int k = 0; k < conv_pkg::MAX_MACS; k++) begin
            if (g < int'(active)) begin
                data_lanes[k] = patch_i[j];
            end
            j = j + 1;
            if (j == int'(cfg.total_macs)) begin
                j = 0;
                g = g + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mac_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            mac_valid_o <= beat_i;
            done_o      <= beat_i && beat_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_i) begin
            data_mac_o   <= data_lanes;
            num_groups_o <= active;
            win_row_o    <= beat_row_i;
            win_col_o    <= beat_col_i;
            oc_base_o    <= beat_oc_i;
            for (int g = 0; g < conv_pkg::MAX_GROUPS; g++) begin
                num_macs_o[g] <= (g < int'(active)) ? cfg.total_macs : '0;
            end
        end
    end

    // slice is already in lane order, mask beyond the active groups
    assign wgt_limit = 7'(num_groups_o * cfg.total_macs);

    always_comb begin
        for (int k = 0; k < conv_pkg::MAX_MACS; k++) begin
            weight_mac_o[k] = (k < int'(wgt_limit)) ? wgt_slice_i[k] : '0;
        end
    end

endmodule

//--- hdl/conv_stager.sv
`timescale 1ns/1ps

module conv_stager #(
    parameter int WEIGHT_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::dim_t       img_row_i,
    input  conv_pkg::dim_t       img_col_i,
    input  conv_pkg::dim_t       ker_row_i,
    input  conv_pkg::dim_t       ker_col_i,
    input  conv_pkg::dim_t       in_channel_i,
    input  conv_pkg::dim_t       out_channel_i,
    input  conv_pkg::dim_t       stride_row_i,
    input  conv_pkg::dim_t       stride_col_i,
    input  logic                 start_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic                 img_rd_o,
    output conv_pkg::addr_t      img_addr_o,
    input  conv_pkg::lane_word_t img_data_i,
    output logic                 wgt_rd_o,
    output conv_pkg::addr_t      wgt_addr_o,
    input  conv_pkg::lane_word_t wgt_data_i,
    output logic                 mac_valid_o,
    output conv_pkg::mac_vec_t   data_mac_o,
    output conv_pkg::mac_vec_t   weight_mac_o,
    output conv_pkg::group_t     num_groups_o,
    output conv_pkg::macs_vec_t  num_macs_o,
    output conv_pkg::dim_t       win_row_o,
    output conv_pkg::dim_t       win_col_o,
    output conv_pkg::oc_t        oc_base_o
);

    conv_cfg_if cfg_if ();

    logic               load_start, load_done;
    logic               gather_start, gather_done;
    conv_pkg::addr_t    gather_base;
    logic               beat, beat_last;
    conv_pkg::oc_t      beat_oc;
    conv_pkg::dim_t     beat_row, beat_col;
    conv_pkg::mac_vec_t patch, wgt_slice;

    conv_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .img_row_i      (img_row_i),
        .img_col_i      (img_col_i),
        .ker_row_i      (ker_row_i),
        .ker_col_i      (ker_col_i),
        .in_channel_i   (in_channel_i),
        .out_channel_i  (out_channel_i),
        .stride_row_i   (stride_row_i),
        .stride_col_i   (stride_col_i),
        .cfg            (cfg_if.ctrl),
        .load_start_o   (load_start),
        .load_done_i    (load_done),
        .gather_start_o (gather_start),
        .gather_base_o  (gather_base),
        .gather_done_i  (gather_done),
        .beat_o         (beat),
        .beat_oc_o      (beat_oc),
        .beat_row_o     (beat_row),
        .beat_col_o     (beat_col),
        .beat_last_o    (beat_last),
        .busy_o         (busy_o)
    );

    patch_fetch i_fetch (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg_if.fetch),
        .gather_start_i (gather_start),
        .gather_base_i  (gather_base),
        .gather_done_o  (gather_done),
        .img_rd_o       (img_rd_o),
        .img_addr_o     (img_addr_o),
        .img_data_i     (img_data_i),
        .patch_o        (patch)
    );

    weight_store #(
        .WEIGHT_DEPTH (WEIGHT_DEPTH)
    ) i_store (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg_if.store),
        .load_start_i (load_start),
        .load_done_o  (load_done),
        .wgt_rd_o     (wgt_rd_o),
        .wgt_addr_o   (wgt_addr_o),
        .wgt_data_i   (wgt_data_i),
        .beat_i       (beat),
        .beat_oc_i    (beat_oc),
        .wgt_slice_o  (wgt_slice)
    );

    mac_packer i_pack (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg_if.pack),
        .beat_i       (beat),
        .beat_oc_i    (beat_oc),
        .beat_row_i   (beat_row),
        .beat_col_i   (beat_col),
        .beat_last_i  (beat_last),
        .patch_i      (patch),
        .wgt_slice_i  (wgt_slice),
        .mac_valid_o  (mac_valid_o),
        .data_mac_o   (data_mac_o),
        .weight_mac_o (weight_mac_o),
        .num_groups_o (num_groups_o),
        .num_macs_o   (num_macs_o),
        .win_row_o    (win_row_o),
        .win_col_o    (win_col_o),
        .oc_base_o    (oc_base_o),
        .done_o       (done_o)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RST_CYCLES  = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // active low, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

//--- test/tb_conv_stager.sv
`timescale 1ns/1ps

module tb_conv_stager;

    localparam int IMG_WORDS = 4096;
    localparam int WGT_WORDS = 2048;
    localparam int TIMEOUT   = 20000;

    logic clk;
    logic rst;

    conv_pkg::dim_t       img_row, img_col, ker_row, ker_col;
    conv_pkg::dim_t       in_channel, out_channel, stride_row, stride_col;
    logic                 start, busy, done;
    logic                 img_rd, wgt_rd;
    conv_pkg::addr_t      img_addr, wgt_addr;
    conv_pkg::lane_word_t img_data, wgt_data;
    logic                 mac_valid;
    conv_pkg::mac_vec_t   data_mac, weight_mac;
    conv_pkg::group_t     num_groups;
    conv_pkg::macs_vec_t  num_macs;
    conv_pkg::dim_t       win_row, win_col;
    conv_pkg::oc_t        oc_base;

    // sram contents
    conv_pkg::elem_t img_mem [IMG_WORDS];
    conv_pkg::elem_t wgt_mem [WGT_WORDS];

    // expected beats in issue order
    conv_pkg::mac_vec_t  exp_data [$];
    conv_pkg::mac_vec_t  exp_wgt [$];
    conv_pkg::group_t    exp_grp [$];
    conv_pkg::macs_vec_t exp_macs [$];
    conv_pkg::dim_t      exp_row [$];
    conv_pkg::dim_t      exp_col [$];
    conv_pkg::oc_t       exp_oc [$];
    logic                exp_last [$];

    // current layer case from the input file
    int irow, icol, krow, kcol, ich, och, srow, scol;
    int exp_windows, exp_groups;
    int win_count;

    tb_clock_gen i_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    conv_stager #(
        .WEIGHT_DEPTH (1024)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .img_row_i     (img_row),
        .img_col_i     (img_col),
        .ker_row_i     (ker_row),
        .ker_col_i     (ker_col),
        .in_channel_i  (in_channel),
        .out_channel_i (out_channel),
        .stride_row_i  (stride_row),
        .stride_col_i  (stride_col),
        .start_i       (start),
        .busy_o        (busy),
        .done_o        (done),
        .img_rd_o      (img_rd),
        .img_addr_o    (img_addr),
        .img_data_i    (img_data),
        .wgt_rd_o      (wgt_rd),
        .wgt_addr_o    (wgt_addr),
        .wgt_data_i    (wgt_data),
        .mac_valid_o   (mac_valid),
        .data_mac_o    (data_mac),
        .weight_mac_o  (weight_mac),
        .num_groups_o  (num_groups),
        .num_macs_o    (num_macs),
        .win_row_o     (win_row),
        .win_col_o     (win_col),
        .oc_base_o     (oc_base)
    );

    // both srams answer one cycle after the strobe at any alignment
    always @(posedge clk) begin
        if (img_rd) begin
            for (int k = 0; k < conv_pkg::LANES; k++) begin
                img_data[k] <= img_mem[(int'(img_addr) + k) % IMG_WORDS];
            end
        end
        if (wgt_rd) begin
            for (int k = 0; k < conv_pkg::LANES; k++) begin
                wgt_data[k] <= wgt_mem[(int'(wgt_addr) + k) % WGT_WORDS];
            end
        end
    end

    task automatic report_fail();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_vec(input string name, input conv_pkg::mac_vec_t got,
                             input conv_pkg::mac_vec_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_macs(input string name, input conv_pkg::macs_vec_t got,
                              input conv_pkg::macs_vec_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_groups(input string name, input conv_pkg::group_t got,
                                input conv_pkg::group_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_pos(input string name, input conv_pkg::dim_t got,
                             input conv_pkg::dim_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            report_fail();
        end
    endtask

    // compare every beat as it leaves the DUT
    always @(negedge clk) begin
        if (rst) begin
            if (mac_valid) begin
                if (exp_data.size() == 0) begin
                    $display("MAC beat seen with no beat left to expect");
                    report_fail();
                end else begin
                    check_vec("data_mac_o", data_mac, exp_data.pop_front());
                    check_vec("weight_mac_o", weight_mac, exp_wgt.pop_front());
                    check_groups("num_groups_o", num_groups, exp_grp.pop_front());
                    check_macs("num_macs_o", num_macs, exp_macs.pop_front());
                    check_pos("win_row_o", win_row, exp_row.pop_front());
                    check_pos("win_col_o", win_col, exp_col.pop_front());
                    check_pos("oc_base_o", oc_base, exp_oc.pop_front());
                    check_bit("done_o", done, exp_last.pop_front());
                    if (oc_base == '0) begin
                        win_count++;
                    end
                end
            end else begin
                check_bit("done_o", done, 1'b0);
            end
        end
    end

    task automatic fill_memories();
        for (int i = 0; i < IMG_WORDS; i++) begin
            img_mem[i] = conv_pkg::elem_t'($urandom);
        end
        for (int i = 0; i < WGT_WORDS; i++) begin
            wgt_mem[i] = conv_pkg::elem_t'($urandom);
        end
    endtask

    // column outer loop, row inner loop and output channel groups innermost
    task automatic build_expected();
        int tm, row_len, pitch, base;
        int r_off, c_off, wr, wc, ob, act;
        conv_pkg::mac_vec_t  patch, dv, wv;
        conv_pkg::macs_vec_t mv;
        tm      = krow * kcol * ich;
        row_len = kcol * ich;
        pitch   = icol * ich;
        wc      = 0;
        for (c_off = 0; c_off + kcol <= icol; c_off += scol) begin
            wr = 0;
            for (r_off = 0; r_off + krow <= irow; r_off += srow) begin
                base  = r_off * pitch + c_off * ich;
                patch = '0;
                for (int k = 0; k < tm; k++) begin
                    patch[k] = img_mem[(base + (k / row_len) * pitch + k % row_len) % IMG_WORDS];
                end
                for (ob = 0; ob < och; ob += exp_groups) begin
                    act = (och - ob < exp_groups) ? och - ob : exp_groups;
                    dv  = '0;
                    wv  = '0;
                    mv  = '0;
                    for (int g = 0; g < act; g++) begin
                        mv[g] = conv_pkg::macs_t'(tm);
                        for (int j = 0; j < tm; j++) begin
                            dv[g * tm + j] = patch[j];
                            wv[g * tm + j] = wgt_mem[(ob * tm + g * tm + j) % WGT_WORDS];
                        end
                    end
                    exp_data.push_back(dv);
                    exp_wgt.push_back(wv);
                    exp_grp.push_back(conv_pkg::group_t'(act));
                    exp_macs.push_back(mv);
                    exp_row.push_back(conv_pkg::dim_t'(wr));
                    exp_col.push_back(conv_pkg::dim_t'(wc));
                    exp_oc.push_back(conv_pkg::oc_t'(ob));
                    exp_last.push_back(1'b0);
                end
                wr++;
            end
            wc++;
        end
        exp_last[exp_last.size() - 1] = 1'b1;
    endtask

    task automatic wait_for_busy(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== level) begin
            n++;
            if (n > TIMEOUT) begin
                $display("timed out waiting for busy_o to become %0d", level);
                report_fail();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                $display("timed out waiting for done_o");
                report_fail();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        @(negedge clk);
        while (rst !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                $display("reset was never released");
                report_fail();
            end
            @(negedge clk);
        end
    endtask

    task automatic run_case();
        fill_memories();
        build_expected();
        win_count = 0;
        @(posedge clk);
        img_row     <= conv_pkg::dim_t'(irow);
        img_col     <= conv_pkg::dim_t'(icol);
        ker_row     <= conv_pkg::dim_t'(krow);
        ker_col     <= conv_pkg::dim_t'(kcol);
        in_channel  <= conv_pkg::dim_t'(ich);
        out_channel <= conv_pkg::dim_t'(och);
        stride_row  <= conv_pkg::dim_t'(srow);
        stride_col  <= conv_pkg::dim_t'(scol);
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_busy(1'b1);
        // a second start while busy must leave the beats alone
        repeat (2) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_done();
        @(negedge clk);
        check_bit("busy_o", busy, 1'b0);
        if (exp_data.size() != 0) begin
            $display("run ended with %0d expected beats never issued", exp_data.size());
            report_fail();
        end
        check_count("window count", win_count, exp_windows);
    endtask

    initial begin
        int    fd;
        int    n;
        int    cases;
        string line;
        start       = 1'b0;
        img_row     = '0;
        img_col     = '0;
        ker_row     = '0;
        ker_col     = '0;
        in_channel  = '0;
        out_channel = '0;
        stride_row  = '0;
        stride_col  = '0;
        img_data    = '0;
        wgt_data    = '0;
        cases       = 0;
        void'($urandom(40600));
        fd = $fopen("test/stager_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/stager_input.txt");
            report_fail();
        end
        wait_for_reset();
        check_bit("busy_o", busy, 1'b0);
        check_bit("done_o", done, 1'b0);
        check_bit("mac_valid_o", mac_valid, 1'b0);
        check_bit("img_rd_o", img_rd, 1'b0);
        check_bit("wgt_rd_o", wgt_rd, 1'b0);
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", irow, icol, krow, kcol,
                            ich, och, srow, scol, exp_windows, exp_groups);
                if (n == 10) begin
                    run_case();
                    cases++;
                end
            end
        end
        $fclose(fd);
        if (cases == 0) begin
            $display("no layer cases found in the input file");
            report_fail();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- test/stager_input.txt
# img_row img_col ker_row ker_col in_channel out_channel stride_row stride_col
# then expected window count and expected groups per beat, all decimal
5 5 3 3 1 4 1 1 9 7
6 7 3 3 3 10 1 2 12 2
8 8 2 2 2 20 2 2 16 8
7 9 3 2 5 6 2 3 9 2
4 4 4 4 4 3 1 1 1 1
10 6 1 1 3 17 3 1 24 8
9 5 2 3 7 12 1 2 16 1
3 12 3 5 1 25 1 4 2 4
6 6 2 5 6 5 4 1 4 1
12 12 3 3 2 9 3 3 16 3
2 2 1 1 1 1 1 1 4 8
16 16 5 5 2 20 4 5 9 1
5 8 2 4 8 4 1 2 12 1
9 9 3 3 4 7 3 3 9 1
6 10 2 2 4 30 2 4 9 4
3 3 3 3 7 2 1 1 1 1
8 4 4 1 5 33 1 1 20 3
5 5 1 5 2 64 2 1 3 6

//--- tb.f
hdl/conv_pkg.sv
hdl/conv_cfg_if.sv
hdl/conv_ctrl.sv
hdl/patch_fetch.sv
hdl/weight_store.sv
hdl/mac_packer.sv
hdl/conv_stager.sv
test/tb_clock_gen.sv
test/tb_conv_stager.sv

//--- run.sh
#!/bin/sh
# build and run the conv stager testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_conv_stager -f tb.f \
    -o tb_conv_stager || exit 1
./obj_dir/tb_conv_stager > sim.log 2>&1 || true
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
